// ==== pcie_example_defines.svh ====
`ifndef PCIE_EXAMPLE_DEFINES_SVH
`define PCIE_EXAMPLE_DEFINES_SVH

// bus and field widths.
`define PCIE_EX_DATA_WIDTH    32
`define PCIE_EX_ADDR_WIDTH    10
`define PCIE_EX_TAG_WIDTH     8
`define PCIE_EX_REQ_ID_WIDTH  16

// number of mapped dwords at the bottom of BAR0.
`define PCIE_EX_REG_COUNT     8

`define PCIE_EX_ID_VALUE      32'h5043_0e01

// dword offsets inside BAR0.
`define PCIE_EX_REG_ID           10'd0
`define PCIE_EX_REG_SCRATCH      10'd1
`define PCIE_EX_REG_LED          10'd2
`define PCIE_EX_REG_MSIX_ADDR_LO 10'd3
`define PCIE_EX_REG_MSIX_ADDR_HI 10'd4
`define PCIE_EX_REG_MSIX_DATA    10'd5
`define PCIE_EX_REG_DOORBELL     10'd6
`define PCIE_EX_REG_SENT_COUNT   10'd7

`endif

// ==== pcie_example_pkg.sv ====
`include "pcie_example_defines.svh"

package pcie_example_pkg;

    typedef logic [`PCIE_EX_DATA_WIDTH-1:0]   word_t;
    typedef logic [`PCIE_EX_DATA_WIDTH/8-1:0] byte_en_t;
    typedef logic [`PCIE_EX_ADDR_WIDTH-1:0]   reg_addr_t;
    typedef logic [`PCIE_EX_TAG_WIDTH-1:0]    tag_t;
    typedef logic [`PCIE_EX_REQ_ID_WIDTH-1:0] req_id_t;
    typedef logic [63:0]                      msix_addr_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } req_op_t;

    // completion status, PCIe encoding.
    typedef enum logic [2:0] {
        cpl_sc = 3'b000,
        cpl_ur = 3'b001
    } cpl_status_t;

    // one single-beat request from the CQ side.
    typedef struct packed {
        req_op_t   op;
        reg_addr_t addr;
        byte_en_t  byte_en;
        word_t     data;
        tag_t      tag;
        req_id_t   req_id;
    } cq_req_t;

    typedef struct packed {
        cpl_status_t status;
        tag_t        tag;
        req_id_t     req_id;
        word_t       data;
    } cc_cpl_t;

    typedef enum logic {
        st_idle      = 1'b0,
        st_wait_done = 1'b1
    } msix_state_t;

endpackage

// ==== bar_regs.sv ====
`include "pcie_example_defines.svh"

module bar_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        reg_wr_en,
    input  logic                        reg_rd_en,
    input  pcie_example_pkg::reg_addr_t reg_addr,
    input  pcie_example_pkg::word_t     reg_wdata,
    input  pcie_example_pkg::byte_en_t  reg_byte_en,
    input  logic                        sent_inc,
    output pcie_example_pkg::word_t     reg_rdata,
    output logic                        reg_hit,
    output logic                        doorbell,
    output pcie_example_pkg::msix_addr_t msix_addr,
    output pcie_example_pkg::word_t     msix_data,
    output logic [5:0]                  led,
    output logic                        status_error_uncor
);

    pcie_example_pkg::word_t scratch_reg;
    pcie_example_pkg::word_t led_reg;
    pcie_example_pkg::word_t addr_lo_reg;
    pcie_example_pkg::word_t addr_hi_reg;
    pcie_example_pkg::word_t data_reg;
    pcie_example_pkg::word_t sent_count;

    // keep old bytes where the enable is clear.
    function automatic pcie_example_pkg::word_t merge_bytes(
        input pcie_example_pkg::word_t    old_val,
        input pcie_example_pkg::word_t    new_val,
        input pcie_example_pkg::byte_en_t be
    );
        pcie_example_pkg::word_t result;
        result = old_val;
        for (int i = 0; i < $bits(pcie_example_pkg::byte_en_t); i++) begin
            if (be[i]) begin
                result[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return result;
    endfunction

    assign reg_hit = reg_addr < `PCIE_EX_ADDR_WIDTH'(`PCIE_EX_REG_COUNT);

    // read mux, doorbell reads as zero.
    always_comb begin
        case (reg_addr)
            `PCIE_EX_REG_ID:           reg_rdata = `PCIE_EX_ID_VALUE;
            `PCIE_EX_REG_SCRATCH:      reg_rdata = scratch_reg;
            `PCIE_EX_REG_LED:          reg_rdata = led_reg;
            `PCIE_EX_REG_MSIX_ADDR_LO: reg_rdata = addr_lo_reg;
            `PCIE_EX_REG_MSIX_ADDR_HI: reg_rdata = addr_hi_reg;
            `PCIE_EX_REG_MSIX_DATA:    reg_rdata = data_reg;
            `PCIE_EX_REG_SENT_COUNT:   reg_rdata = sent_count;
            default:                   reg_rdata = '0;
        endcase
    end

    // ID and sent count ignore writes.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch_reg <= '0;
            led_reg     <= '0;
            addr_lo_reg <= '0;
            addr_hi_reg <= '0;
            data_reg    <= '0;
            sent_count  <= '0;
        end else begin
            if (reg_wr_en) begin
                case (reg_addr)
                    `PCIE_EX_REG_SCRATCH:
                        scratch_reg <= merge_bytes(scratch_reg, reg_wdata, reg_byte_en);
                    `PCIE_EX_REG_LED:
                        led_reg <= merge_bytes(led_reg, reg_wdata, reg_byte_en);
                    `PCIE_EX_REG_MSIX_ADDR_LO:
                        addr_lo_reg <= merge_bytes(addr_lo_reg, reg_wdata, reg_byte_en);
                    `PCIE_EX_REG_MSIX_ADDR_HI:
                        addr_hi_reg <= merge_bytes(addr_hi_reg, reg_wdata, reg_byte_en);
                    `PCIE_EX_REG_MSIX_DATA:
                        data_reg <= merge_bytes(data_reg, reg_wdata, reg_byte_en);
                    default: ;
                endcase
            end
            if (sent_inc) begin
                sent_count <= sent_count + 1'b1;
            end
        end
    end

    // strobes, one cycle after the access.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            doorbell           <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            doorbell           <= reg_wr_en && (reg_addr == `PCIE_EX_REG_DOORBELL);
            status_error_uncor <= (reg_wr_en || reg_rd_en) && !reg_hit;
        end
    end

    assign msix_addr = {addr_hi_reg, addr_lo_reg};
    assign msix_data = data_reg;
    assign led       = led_reg[5:0];

    // the decoder issues one access per accepted request.
    a_single_access: assert property (@(posedge clk) disable iff (!rst_n)
        !(reg_wr_en && reg_rd_en));

endmodule

// ==== cq_decoder.sv ====
module cq_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  pcie_example_pkg::cq_req_t   cq_req,
    input  logic                        cq_valid,
    output logic                        cq_ready,
    input  logic                        slot_free,
    output logic                        reg_wr_en,
    output logic                        reg_rd_en,
    output pcie_example_pkg::reg_addr_t reg_addr,
    output pcie_example_pkg::word_t     reg_wdata,
    output pcie_example_pkg::byte_en_t  reg_byte_en,
    input  pcie_example_pkg::word_t     reg_rdata,
    input  logic                        reg_hit,
    output logic                        cpl_load,
    output pcie_example_pkg::cc_cpl_t   cpl_in
);

    logic accept;

    // take a request only when the completion slot can hold its answer.
    assign cq_ready = slot_free;
    assign accept   = cq_valid && cq_ready;

    // steer struct fields to the register port.
    assign reg_wr_en   = accept && (cq_req.op == pcie_example_pkg::op_write);
    assign reg_rd_en   = accept && (cq_req.op == pcie_example_pkg::op_read);
    assign reg_addr    = cq_req.addr;
    assign reg_wdata   = cq_req.data;
    assign reg_byte_en = cq_req.byte_en;

    // reads only, writes are posted.
    assign cpl_load = reg_rd_en;

    always_comb begin
        cpl_in.tag    = cq_req.tag;
        cpl_in.req_id = cq_req.req_id;
        if (reg_hit) begin
            cpl_in.status = pcie_example_pkg::cpl_sc;
            cpl_in.data   = reg_rdata;
        end else begin
            // unmapped offset.
            cpl_in.status = pcie_example_pkg::cpl_ur;
            cpl_in.data   = '0;
        end
    end

    // source must hold a stalled request.
    a_cq_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (cq_valid && !cq_ready) |=> (cq_valid && $stable(cq_req)));

endmodule

// ==== cc_builder.sv ====
module cc_builder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cpl_load,
    input  pcie_example_pkg::cc_cpl_t cpl_in,
    output logic                      slot_free,
    output pcie_example_pkg::cc_cpl_t cc_cpl,
    input  logic                      cc_ready,
    output logic                      cc_valid
);

    pcie_example_pkg::cc_cpl_t cpl_reg;
    logic                      valid_reg;

    // empty, or draining this cycle.
    assign slot_free = !valid_reg || cc_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_reg <= 1'b0;
        end else if (cpl_load) begin
            valid_reg <= 1'b1;
        end else if (cc_ready) begin
            valid_reg <= 1'b0;
        end
    end

    // payload only moves on load.
    always_ff @(posedge clk) begin
        if (cpl_load) begin
            cpl_reg <= cpl_in;
        end
    end

    assign cc_cpl   = cpl_reg;
    assign cc_valid = valid_reg;

    // a load into a full slot would overwrite an unsent completion.
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        cpl_load |-> slot_free);

endmodule

// ==== msix_gen.sv ====
module msix_gen (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         doorbell,
    input  pcie_example_pkg::msix_addr_t msix_addr,
    input  pcie_example_pkg::word_t      msix_data,
    input  logic                         msix_enable,
    input  logic                         msix_mask,
    output logic                         msix_int,
    output pcie_example_pkg::msix_addr_t msix_address,
    output pcie_example_pkg::word_t      msix_message,
    input  logic                         msix_sent,
    input  logic                         msix_fail,
    output logic                         sent_inc,
    output logic                         status_error_cor
);

    pcie_example_pkg::msix_state_t state;
    logic                          pending;
    logic                          fire;
    logic                          done;

    // a new doorbell may fire directly from idle.
    assign fire = (state == pcie_example_pkg::st_idle) && (pending || doorbell)
                  && msix_enable && !msix_mask;
    assign done = (state == pcie_example_pkg::st_wait_done) && (msix_sent || msix_fail);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= pcie_example_pkg::st_idle;
            pending          <= 1'b0;
            msix_int         <= 1'b0;
            sent_inc         <= 1'b0;
            status_error_cor <= 1'b0;
        end else begin
            msix_int         <= fire;
            sent_inc         <= done && msix_sent;
            status_error_cor <= done && msix_fail;
            if (fire) begin
                state   <= pcie_example_pkg::st_wait_done;
                pending <= 1'b0;
            end else begin
                // held until the function is enabled and unmasked.
                if (doorbell) begin
                    pending <= 1'b1;
                end
                if (done) begin
                    state <= pcie_example_pkg::st_idle;
                end
            end
        end
    end

    // address and data are frozen for the whole request.
    always_ff @(posedge clk) begin
        if (fire) begin
            msix_address <= msix_addr;
            msix_message <= msix_data;
        end
    end

    a_result_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (msix_sent || msix_fail) |-> (state == pcie_example_pkg::st_wait_done));

endmodule

// ==== fpga_core.sv ====
module fpga_core (
    // clock and reset
    input  logic                         clk,
    input  logic                         rst_n,

    // LEDs
    output logic [1:0]                   sfp_1_led,
    output logic [1:0]                   sfp_2_led,
    output logic [1:0]                   sma_led,

    // completer request
    input  pcie_example_pkg::cq_req_t    cq_req,
    input  logic                         cq_valid,
    output logic                         cq_ready,

    // completer completion
    output pcie_example_pkg::cc_cpl_t    cc_cpl,
    output logic                         cc_valid,
    input  logic                         cc_ready,

    // MSI-X
    input  logic                         msix_enable,
    input  logic                         msix_mask,
    output logic                         msix_int,
    output pcie_example_pkg::msix_addr_t msix_address,
    output pcie_example_pkg::word_t      msix_message,
    input  logic                         msix_sent,
    input  logic                         msix_fail,

    // status
    output logic                         status_error_cor,
    output logic                         status_error_uncor
);

    logic                         slot_free;
    logic                         reg_wr_en;
    logic                         reg_rd_en;
    pcie_example_pkg::reg_addr_t  reg_addr;
    pcie_example_pkg::word_t      reg_wdata;
    pcie_example_pkg::byte_en_t   reg_byte_en;
    pcie_example_pkg::word_t      reg_rdata;
    logic                         reg_hit;
    logic                         cpl_load;
    pcie_example_pkg::cc_cpl_t    cpl_in;
    logic                         doorbell;
    pcie_example_pkg::msix_addr_t msix_addr;
    pcie_example_pkg::word_t      msix_data;
    logic                         sent_inc;
    logic [5:0]                   led;

    // two LED bits per connector.
    assign sfp_1_led = led[1:0];
    assign sfp_2_led = led[3:2];
    assign sma_led   = led[5:4];

    cq_decoder cq_decoder_inst (
        .clk(clk),
        .rst_n(rst_n),
        .cq_req(cq_req),
        .cq_valid(cq_valid),
        .cq_ready(cq_ready),
        .slot_free(slot_free),
        .reg_wr_en(reg_wr_en),
        .reg_rd_en(reg_rd_en),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_byte_en(reg_byte_en),
        .reg_rdata(reg_rdata),
        .reg_hit(reg_hit),
        .cpl_load(cpl_load),
        .cpl_in(cpl_in)
    );

    bar_regs bar_regs_inst (
        .clk(clk),
        .rst_n(rst_n),
        .reg_wr_en(reg_wr_en),
        .reg_rd_en(reg_rd_en),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_byte_en(reg_byte_en),
        .sent_inc(sent_inc),
        .reg_rdata(reg_rdata),
        .reg_hit(reg_hit),
        .doorbell(doorbell),
        .msix_addr(msix_addr),
        .msix_data(msix_data),
        .led(led),
        .status_error_uncor(status_error_uncor)
    );

    cc_builder cc_builder_inst (
        .clk(clk),
        .rst_n(rst_n),
        .cpl_load(cpl_load),
        .cpl_in(cpl_in),
        .slot_free(slot_free),
        .cc_cpl(cc_cpl),
        .cc_ready(cc_ready),
        .cc_valid(cc_valid)
    );

    msix_gen msix_gen_inst (
        .clk(clk),
        .rst_n(rst_n),
        .doorbell(doorbell),
        .msix_addr(msix_addr),
        .msix_data(msix_data),
        .msix_enable(msix_enable),
        .msix_mask(msix_mask),
        .msix_int(msix_int),
        .msix_address(msix_address),
        .msix_message(msix_message),
        .msix_sent(msix_sent),
        .msix_fail(msix_fail),
        .sent_inc(sent_inc),
        .status_error_cor(status_error_cor)
    );

endmodule

// ==== tb_fpga_core.sv ====
`include "pcie_example_defines.svh"

module tb_fpga_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 200;

    logic                         clk;
    logic                         rst_n;
    logic [1:0]                   sfp_1_led;
    logic [1:0]                   sfp_2_led;
    logic [1:0]                   sma_led;
    pcie_example_pkg::cq_req_t    cq_req;
    logic                         cq_valid;
    logic                         cq_ready;
    pcie_example_pkg::cc_cpl_t    cc_cpl;
    logic                         cc_valid;
    logic                         cc_ready;
    logic                         msix_enable;
    logic                         msix_mask;
    logic                         msix_int;
    pcie_example_pkg::msix_addr_t msix_address;
    pcie_example_pkg::word_t      msix_message;
    logic                         msix_sent;
    logic                         msix_fail;
    logic                         status_error_cor;
    logic                         status_error_uncor;

    // reference model.
    pcie_example_pkg::word_t      exp_regs [0:7];
    pcie_example_pkg::cc_cpl_t    exp_cpl [0:63];
    logic [5:0]                   cpl_wr_ptr;
    logic [5:0]                   cpl_rd_ptr;
    logic                         cq_fire;
    logic                         db_seen;
    logic                         sent_seen;
    logic                         irq_pending;
    logic                         irq_busy;
    logic                         exp_int;
    logic                         exp_cor;
    logic                         exp_uncor;
    pcie_example_pkg::msix_addr_t exp_address;
    pcie_example_pkg::word_t      exp_message;
    int                           uncor_pulses;

    integer                       seed;
    int                           errors;
    int                           tests_passed;
    int                           tests_failed;
    logic                         stall_en;
    pcie_example_pkg::tag_t       next_tag;

    fpga_core fpga_core_inst (
        .clk(clk),
        .rst_n(rst_n),
        .sfp_1_led(sfp_1_led),
        .sfp_2_led(sfp_2_led),
        .sma_led(sma_led),
        .cq_req(cq_req),
        .cq_valid(cq_valid),
        .cq_ready(cq_ready),
        .cc_cpl(cc_cpl),
        .cc_valid(cc_valid),
        .cc_ready(cc_ready),
        .msix_enable(msix_enable),
        .msix_mask(msix_mask),
        .msix_int(msix_int),
        .msix_address(msix_address),
        .msix_message(msix_message),
        .msix_sent(msix_sent),
        .msix_fail(msix_fail),
        .status_error_cor(status_error_cor),
        .status_error_uncor(status_error_uncor)
    );

    always #5 clk = ~clk;

    function automatic pcie_example_pkg::word_t apply_byte_enables(
        input pcie_example_pkg::word_t    old_val,
        input pcie_example_pkg::word_t    new_val,
        input pcie_example_pkg::byte_en_t be
    );
        pcie_example_pkg::word_t result;
        for (int b = 0; b < 4; b++) begin
            result[b*8 +: 8] = be[b] ? new_val[b*8 +: 8] : old_val[b*8 +: 8];
        end
        return result;
    endfunction

    // doorbell is never stored, so it reads as zero.
    function automatic pcie_example_pkg::cc_cpl_t expected_cpl(
        input pcie_example_pkg::cq_req_t req
    );
        pcie_example_pkg::cc_cpl_t cpl;
        cpl.tag    = req.tag;
        cpl.req_id = req.req_id;
        if (req.addr < 10'd8) begin
            cpl.status = pcie_example_pkg::cpl_sc;
            cpl.data   = exp_regs[req.addr[2:0]];
        end else begin
            cpl.status = pcie_example_pkg::cpl_ur;
            cpl.data   = '0;
        end
        return cpl;
    endfunction

    function automatic void flag_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t ns: %s", $time, msg);
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_regs     <= '{0: `PCIE_EX_ID_VALUE, default: '0};
            cpl_wr_ptr   <= '0;
            cpl_rd_ptr   <= '0;
            cq_fire      <= 1'b0;
            db_seen      <= 1'b0;
            sent_seen    <= 1'b0;
            irq_pending  <= 1'b0;
            irq_busy     <= 1'b0;
            exp_int      <= 1'b0;
            exp_cor      <= 1'b0;
            exp_uncor    <= 1'b0;
            uncor_pulses <= 0;
        end else begin
            cq_fire   <= cq_valid && cq_ready;
            exp_uncor <= cq_valid && cq_ready && (cq_req.addr >= 10'd8);
            db_seen   <= cq_valid && cq_ready && (cq_req.op == pcie_example_pkg::op_write)
                         && (cq_req.addr == `PCIE_EX_REG_DOORBELL);
            if (cq_valid && cq_ready) begin
                // only scratch, LED and the MSI-X registers take writes.
                if (cq_req.op == pcie_example_pkg::op_write
                        && cq_req.addr >= `PCIE_EX_REG_SCRATCH
                        && cq_req.addr <= `PCIE_EX_REG_MSIX_DATA) begin
                    exp_regs[cq_req.addr[2:0]] <= apply_byte_enables(
                        exp_regs[cq_req.addr[2:0]], cq_req.data, cq_req.byte_en);
                end
                if (cq_req.op == pcie_example_pkg::op_read) begin
                    exp_cpl[cpl_wr_ptr] <= expected_cpl(cq_req);
                    cpl_wr_ptr          <= cpl_wr_ptr + 6'd1;
                end
            end
            if (cc_valid && cc_ready) begin
                cpl_rd_ptr <= cpl_rd_ptr + 6'd1;
            end
            if (status_error_uncor) begin
                uncor_pulses <= uncor_pulses + 1;
            end
            // counter moves one cycle after the sent answer.
            sent_seen <= msix_sent && irq_busy;
            if (sent_seen) begin
                exp_regs[7] <= exp_regs[7] + 32'd1;
            end
            exp_int <= 1'b0;
            exp_cor <= irq_busy && msix_fail;
            if (!irq_busy && (irq_pending || db_seen) && msix_enable && !msix_mask) begin
                exp_int     <= 1'b1;
                irq_busy    <= 1'b1;
                irq_pending <= 1'b0;
                exp_address <= {exp_regs[4], exp_regs[3]};
                exp_message <= exp_regs[5];
            end else begin
                if (db_seen) begin
                    irq_pending <= 1'b1;
                end
                if (irq_busy && (msix_sent || msix_fail)) begin
                    irq_busy <= 1'b0;
                end
            end
        end
    end

    a_cpl_expected: assert property (@(posedge clk) disable iff (!rst_n)
        cc_valid |-> (cpl_rd_ptr != cpl_wr_ptr))
        else flag_mismatch("completion with no read outstanding");
    a_cpl_value: assert property (@(posedge clk) disable iff (!rst_n)
        cc_valid |-> (cc_cpl == exp_cpl[cpl_rd_ptr]))
        else flag_mismatch("completion status, tag, requester ID or data differ");
    a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        (cc_valid && !cc_ready) |-> !cq_ready)
        else flag_mismatch("cq_ready high while a completion is stalled");
    a_ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !cc_valid |-> cq_ready)
        else flag_mismatch("cq_ready low with the completion slot empty");
    a_led: assert property (@(posedge clk) disable iff (!rst_n)
        {sma_led, sfp_2_led, sfp_1_led} == exp_regs[2][5:0])
        else flag_mismatch("LED outputs differ from the LED register");
    a_uncor: assert property (@(posedge clk) disable iff (!rst_n)
        status_error_uncor == exp_uncor)
        else flag_mismatch("status_error_uncor differs");
    a_cor: assert property (@(posedge clk) disable iff (!rst_n)
        status_error_cor == exp_cor)
        else flag_mismatch("status_error_cor differs");
    a_int: assert property (@(posedge clk) disable iff (!rst_n)
        msix_int == exp_int)
        else flag_mismatch("msix_int differs");
    a_int_payload: assert property (@(posedge clk) disable iff (!rst_n)
        msix_int |-> (msix_address == exp_address && msix_message == exp_message))
        else flag_mismatch("MSI-X address or message differ");

    task automatic give_up(input string what);
        $display("timeout: no %s after %0d cycles", what, wait_limit);
        $display("*** FAILED ***");
        $finish;
    endtask

    // next falling edge, with a random stall on cc_ready.
    task automatic tick();
        logic [31:0] r;
        @(negedge clk);
        if (stall_en) begin
            r = $random(seed);
            cc_ready = r[0] | r[1];
        end else begin
            cc_ready = 1'b1;
        end
    endtask

    task automatic send_req(
        input pcie_example_pkg::req_op_t   op,
        input pcie_example_pkg::reg_addr_t addr,
        input pcie_example_pkg::byte_en_t  be,
        input pcie_example_pkg::word_t     data
    );
        logic [31:0] r;
        int          waited;
        r              = $random(seed);
        cq_req.op      = op;
        cq_req.addr    = addr;
        cq_req.byte_en = be;
        cq_req.data    = data;
        cq_req.tag     = next_tag;
        cq_req.req_id  = r[15:0];
        next_tag       = next_tag + 8'd1;
        cq_valid       = 1'b1;
        waited         = 0;
        do begin
            tick();
            waited++;
            if (waited > wait_limit) begin
                give_up("request acceptance on the CQ port");
            end
        end while (!cq_fire);
        cq_valid = 1'b0;
    endtask

    task automatic write_reg(input pcie_example_pkg::reg_addr_t addr,
                             input pcie_example_pkg::byte_en_t be,
                             input pcie_example_pkg::word_t data);
        send_req(pcie_example_pkg::op_write, addr, be, data);
    endtask

    task automatic read_reg(input pcie_example_pkg::reg_addr_t addr);
        send_req(pcie_example_pkg::op_read, addr, 4'hf, '0);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (cpl_rd_ptr != cpl_wr_ptr || cc_valid) begin
            tick();
            waited++;
            if (waited > wait_limit) begin
                give_up("completion on the CC port");
            end
        end
    endtask

    task automatic wait_irq();
        int waited;
        waited = 0;
        while (!msix_int) begin
            tick();
            waited++;
            if (waited > wait_limit) begin
                give_up("MSI-X interrupt");
            end
        end
    endtask

    task automatic answer_irq(input logic ok);
        msix_sent = ok;
        msix_fail = !ok;
        tick();
        msix_sent = 1'b0;
        msix_fail = 1'b0;
        repeat (2) tick();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - errs_before);
        end
    endtask

    initial begin
        int          errs_before;
        logic [31:0] r;
        seed         = 32'hcb9e;
        clk          = 1'b0;
        rst_n        = 1'b0;
        cq_req       = '0;
        cq_valid     = 1'b0;
        cc_ready     = 1'b1;
        msix_enable  = 1'b0;
        msix_mask    = 1'b0;
        msix_sent    = 1'b0;
        msix_fail    = 1'b0;
        stall_en     = 1'b0;
        next_tag     = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        tick();

        errs_before = errors;
        read_reg(`PCIE_EX_REG_ID);
        wait_drain();
        finish_test("reset values", errs_before);

        errs_before = errors;
        write_reg(`PCIE_EX_REG_SCRATCH, 4'hf, 32'h1234_5678);
        write_reg(`PCIE_EX_REG_SCRATCH, 4'b0101, 32'haabb_ccdd);
        write_reg(`PCIE_EX_REG_LED, 4'h1, 32'hffff_ff2a);
        read_reg(`PCIE_EX_REG_LED);
        write_reg(`PCIE_EX_REG_LED, 4'h3, 32'h0000_0015);
        write_reg(`PCIE_EX_REG_MSIX_ADDR_LO, 4'hf, 32'hfee0_0000);
        write_reg(`PCIE_EX_REG_MSIX_ADDR_HI, 4'b0011, 32'hffff_0001);
        write_reg(`PCIE_EX_REG_MSIX_DATA, 4'hf, $random(seed));
        write_reg(`PCIE_EX_REG_ID, 4'hf, 32'hdead_beef);
        write_reg(`PCIE_EX_REG_SENT_COUNT, 4'hf, 32'h0000_0055);
        for (int a = 0; a < 8; a++) begin
            read_reg(pcie_example_pkg::reg_addr_t'(a));
        end
        wait_drain();
        finish_test("register writes and reads", errs_before);

        errs_before = errors;
        stall_en = 1'b1;
        repeat (24) begin
            r = $random(seed);
            read_reg({7'd0, r[2:0]});
        end
        wait_drain();
        stall_en = 1'b0;
        finish_test("completions under back-pressure", errs_before);

        errs_before = errors;
        read_reg(10'd8);
        read_reg(10'h3ff);
        write_reg(10'd100, 4'hf, 32'h0000_0001);
        read_reg(10'd513);
        wait_drain();
        repeat (2) tick();
        assert (uncor_pulses == 4)
            else flag_mismatch("status_error_uncor pulse count is not one per access");
        finish_test("unmapped offsets", errs_before);

        errs_before = errors;
        msix_enable = 1'b1;
        write_reg(`PCIE_EX_REG_MSIX_ADDR_LO, 4'hf, 32'hfee0_1000);
        write_reg(`PCIE_EX_REG_MSIX_DATA, 4'hf, 32'h0000_00a5);
        write_reg(`PCIE_EX_REG_DOORBELL, 4'hf, 32'h0000_0001);
        wait_irq();
        answer_irq(1'b1);
        read_reg(`PCIE_EX_REG_SENT_COUNT);
        wait_drain();
        finish_test("doorbell enabled", errs_before);

        errs_before = errors;
        msix_mask = 1'b1;
        write_reg(`PCIE_EX_REG_DOORBELL, 4'hf, 32'h0000_0001);
        repeat (12) tick();
        msix_mask = 1'b0;
        wait_irq();
        answer_irq(1'b0);
        read_reg(`PCIE_EX_REG_SENT_COUNT);
        wait_drain();
        repeat (4) tick();
        finish_test("doorbell masked then failed", errs_before);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
pcie_example_pkg.sv
bar_regs.sv
cq_decoder.sv
cc_builder.sv
msix_gen.sv
fpga_core.sv
tb_fpga_core.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --assert --timescale 1ns/1ps -f all.f \
    --top-module tb_fpga_core -o tb_fpga_core 2>&1 && ./obj_dir/tb_fpga_core 2>&1)
echo "$out"
echo "$out" | grep -q '\*\*\* PASSED \*\*\*' && exit 0 || exit 1
